// ==== chart_pkg.sv ====
package chart_pkg;

    // Note word: octave down, octave up, then one-hot keys C to B
    typedef logic [8:0] note_t;

    // Chart position and chart length
    typedef logic [5:0] note_idx_t;

    typedef logic [13:0] score_t;

    // Bit 0 octave marker, bits 7..1 keys with C on top
    typedef logic [7:0] led_t;

    typedef logic [1:0] digit_t;
    typedef logic [7:0] chart_id_t;

    // Divider counters, wide enough for the longest period
    typedef logic [3:0] tick_t;

    // Save stream credit count
    typedef logic [2:0] credit_t;

    // Record memory depth and hard index limit
    localparam int CHART_LEN = 32;
    localparam int REC_AW = $clog2(CHART_LEN);
    typedef logic [REC_AW-1:0] rec_addr_t;

    // Cycles per countdown digit, per note and per scoring scan
    localparam int COUNT_TICKS = 8;
    localparam int NOTE_TICKS = 12;
    localparam int SCAN_TICKS = 4;

    // Judge grades
    localparam score_t PTS_PERFECT = 14'd5;
    localparam score_t PTS_GREAT = 14'd3;
    localparam score_t PTS_GOOD = 14'd2;

    localparam credit_t RECORD_CREDITS = 3'd4;

    typedef enum logic [1:0] {
        COUNTDOWN,
        PLAYING,
        FINISHED,
        SAVING
    } play_state_t;

endpackage

// ==== chart_player.sv ====
module chart_player import chart_pkg::*; (
    input  logic      prog_clk,
    input  logic      rst,

    // Player keys and run mode
    input  note_t     user_note,
    input  logic      auto_play,
    input  logic      free_play,

    // External chart read port
    input  note_t     chart_note,
    input  note_idx_t chart_len,

    // Save and exit controls
    input  logic      save_key,
    input  logic      exit_key,
    input  chart_id_t chart_id,
    input  logic      credit_return,

    // Play status
    output digit_t    count_digit,
    output logic      play_started,
    output logic      playing,
    output logic      finished,

    output note_idx_t note_index,
    output note_t     play_note,
    output led_t      led,

    output score_t    score,
    output score_t    max_score,

    output logic      exit_req,

    // Save stream
    output logic      rec_valid,
    output note_idx_t rec_index,
    output note_t     rec_note,
    output chart_id_t rec_chart_id,
    output logic      save_busy
);

    logic note_tick;

    countdown_timer u_countdown (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .count_digit  (count_digit),
        .play_started (play_started)
    );

    note_sequencer u_sequencer (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .play_started (play_started),
        .auto_play    (auto_play),
        .free_play    (free_play),
        .chart_note   (chart_note),
        .chart_len    (chart_len),
        .user_note    (user_note),
        .exit_key     (exit_key),
        .note_index   (note_index),
        .note_tick    (note_tick),
        .playing      (playing),
        .finished     (finished),
        .play_note    (play_note),
        .led          (led),
        .exit_req     (exit_req)
    );

    score_judge u_judge (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .play_started (play_started),
        .playing      (playing),
        .auto_play    (auto_play),
        .free_play    (free_play),
        .chart_note   (chart_note),
        .user_note    (user_note),
        .score        (score),
        .max_score    (max_score)
    );

    record_writer u_writer (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .note_tick     (note_tick),
        .note_index    (note_index),
        .user_note     (user_note),
        .finished      (finished),
        .save_key      (save_key),
        .chart_id      (chart_id),
        .credit_return (credit_return),
        .rec_valid     (rec_valid),
        .rec_index     (rec_index),
        .rec_note      (rec_note),
        .rec_chart_id  (rec_chart_id),
        .save_busy     (save_busy)
    );

endmodule

// ==== chart_player_properties.sv ====
module chart_player_properties import chart_pkg::*; (
    input logic   prog_clk,
    input logic   rst,
    input logic   rec_valid,
    input logic   credit_return,
    input logic   save_busy,
    input logic   play_started,
    input score_t score,
    input score_t max_score
);

    timeunit 1ns;
    timeprecision 100ps;

    // Beats shown minus credits given back
    logic [3:0] outstanding;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(rec_valid) - 4'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge prog_clk) disable iff (rst)
        outstanding <= 4'(RECORD_CREDITS))
        else $error("More save beats outstanding than credits");

    valid_in_save: assert property (@(posedge prog_clk) disable iff (rst)
        rec_valid |-> save_busy)
        else $error("rec_valid seen outside a save");

    start_sticky: assert property (@(posedge prog_clk) disable iff (rst)
        !$fell(play_started))
        else $error("play_started fell during a run");

    score_bound: assert property (@(posedge prog_clk) disable iff (rst)
        score <= max_score)
        else $error("score above max_score");

endmodule

bind chart_player chart_player_properties u_props (.*);

// ==== countdown_timer.sv ====
module countdown_timer import chart_pkg::*; (
    input  logic   prog_clk,
    input  logic   rst,
    output digit_t count_digit,
    output logic   play_started
);

    tick_t tick_cnt;

    // Digit steps 3, 2, 1, 0, then one more period before play
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            count_digit <= 2'd3;
            play_started <= 1'b0;
        end else if (!play_started) begin
            if (tick_cnt == tick_t'(COUNT_TICKS - 1)) begin
                tick_cnt <= '0;
                if (count_digit == '0) begin
                    // Sticky until the next reset
                    play_started <= 1'b1;
                end else begin
                    count_digit <= count_digit - 2'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + tick_t'(1);
            end
        end
    end

endmodule

// ==== note_sequencer.sv ====
module note_sequencer import chart_pkg::*; (
    input  logic      prog_clk,
    input  logic      rst,
    input  logic      play_started,
    input  logic      auto_play,
    input  logic      free_play,
    input  note_t     chart_note,
    input  note_idx_t chart_len,
    input  note_t     user_note,
    input  logic      exit_key,
    output note_idx_t note_index,
    output logic      note_tick,
    output logic      playing,
    output logic      finished,
    output note_t     play_note,
    output led_t      led,
    output logic      exit_req
);

    play_state_t state;
    tick_t       note_cnt;
    note_idx_t   idx_limit;
    led_t        led_next;

    // Free play and empty charts run the whole index range
    always_comb begin
        if (free_play || chart_len == '0) begin
            idx_limit = note_idx_t'(CHART_LEN - 1);
        end else if (chart_len > note_idx_t'(CHART_LEN)) begin
            idx_limit = note_idx_t'(CHART_LEN);
        end else begin
            idx_limit = chart_len;
        end
    end

    assign playing = (state == PLAYING);
    assign finished = (state == FINISHED);
    assign note_tick = playing && (note_cnt == tick_t'(NOTE_TICKS - 1))
                       && (note_index != idx_limit);

    // LED word from the current chart note, C key on bit 7
    always_comb begin
        led_next = '0;
        led_next[0] = chart_note[8] | chart_note[7];
        if ($onehot(chart_note[6:0])) begin
            led_next[7:1] = chart_note[6:0];
        end
    end

    // Note divider starts on the same edge as the scan divider
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_cnt <= '0;
        end else if (!play_started) begin
            note_cnt <= '0;
        end else if (note_cnt == tick_t'(NOTE_TICKS - 1)) begin
            note_cnt <= '0;
        end else begin
            note_cnt <= note_cnt + tick_t'(1);
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= COUNTDOWN;
            note_index <= '0;
            play_note <= '0;
            led <= '0;
        end else begin
            case (state)
                COUNTDOWN: begin
                    if (play_started) begin
                        state <= PLAYING;
                    end
                end
                PLAYING: begin
                    if (note_index == idx_limit) begin
                        state <= FINISHED;
                    end else if (note_tick) begin
                        play_note <= auto_play ? chart_note : user_note;
                        led <= led_next;
                        note_index <= note_index + note_idx_t'(1);
                    end
                end
                default: begin
                    // Finished, stay here until reset
                    state <= FINISHED;
                end
            endcase
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            exit_req <= 1'b0;
        end else if (play_started && exit_key) begin
            exit_req <= 1'b1;
        end
    end

endmodule

// ==== project.f ====
chart_pkg.sv
countdown_timer.sv
note_sequencer.sv
score_judge.sv
record_writer.sv
chart_player.sv
chart_player_properties.sv
tb_chart_player.sv

// ==== record_writer.sv ====
module record_writer import chart_pkg::*; (
    input  logic      prog_clk,
    input  logic      rst,
    input  logic      note_tick,
    input  note_idx_t note_index,
    input  note_t     user_note,
    input  logic      finished,
    input  logic      save_key,
    input  chart_id_t chart_id,
    input  logic      credit_return,
    output logic      rec_valid,
    output note_idx_t rec_index,
    output note_t     rec_note,
    output chart_id_t rec_chart_id,
    output logic      save_busy
);

    note_t       rec_mem [CHART_LEN];
    play_state_t state;
    credit_t     credits;
    note_idx_t   rd_idx;
    note_idx_t   save_len;
    chart_id_t   save_id;
    logic        save_start;
    logic        send_beat;

    assign save_start = (state == FINISHED) && finished && save_key;
    assign send_beat = (state == SAVING) && (credits != '0) && (rd_idx != save_len);

    assign save_busy = (state == SAVING);
    assign rec_chart_id = save_id;

    // User note goes in at the index being left
    always_ff @(posedge prog_clk) begin
        if (note_tick) begin
            rec_mem[rec_addr_t'(note_index)] <= user_note;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (save_start) begin
            save_id <= chart_id;
            save_len <= note_index;
        end
        if (send_beat) begin
            rec_index <= rd_idx;
            rec_note <= rec_mem[rec_addr_t'(rd_idx)];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= COUNTDOWN;
            rd_idx <= '0;
            rec_valid <= 1'b0;
            credits <= RECORD_CREDITS;
        end else begin
            rec_valid <= send_beat;
            credits <= credits + credit_t'(credit_return) - credit_t'(send_beat);
            case (state)
                COUNTDOWN: begin
                    if (note_tick) begin
                        state <= PLAYING;
                    end
                end
                PLAYING: begin
                    if (finished) begin
                        state <= FINISHED;
                    end
                end
                FINISHED: begin
                    if (save_start) begin
                        rd_idx <= '0;
                        state <= SAVING;
                    end
                end
                SAVING: begin
                    if (send_beat) begin
                        rd_idx <= rd_idx + note_idx_t'(1);
                    end
                    // Busy drops once the last beat has been shown
                    if (rec_valid && rec_index == save_len - note_idx_t'(1)) begin
                        state <= FINISHED;
                    end
                end
                default: begin
                    state <= COUNTDOWN;
                end
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_chart_player \
    -f project.f \
    -o sim_chart_player

./obj_dir/sim_chart_player > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== score_judge.sv ====
module score_judge import chart_pkg::*; (
    input  logic   prog_clk,
    input  logic   rst,
    input  logic   play_started,
    input  logic   playing,
    input  logic   auto_play,
    input  logic   free_play,
    input  note_t  chart_note,
    input  note_t  user_note,
    output score_t score,
    output score_t max_score
);

    tick_t scan_cnt;
    logic  scan_tick;
    logic  judge_en;

    // Two most recent pressed notes, newest first
    note_t hist0;
    note_t hist1;

    // Scan divider, aligned with the note divider
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (!play_started) begin
            scan_cnt <= '0;
        end else if (scan_cnt == tick_t'(SCAN_TICKS - 1)) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + tick_t'(1);
        end
    end

    assign scan_tick = play_started && (scan_cnt == tick_t'(SCAN_TICKS - 1));

    // Rests and free play are never judged
    assign judge_en = scan_tick && playing && !free_play && (chart_note[6:0] != '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            max_score <= '0;
            hist0 <= '0;
            hist1 <= '0;
        end else if (judge_en) begin
            max_score <= max_score + PTS_PERFECT;
            if (auto_play) begin
                score <= score + PTS_PERFECT;
            end else if (user_note[6:0] != '0) begin
                // Exact hit first, then the late grades
                if (chart_note == user_note) begin
                    score <= score + PTS_PERFECT;
                end else if (chart_note == hist0) begin
                    score <= score + PTS_GREAT;
                end else if (chart_note == hist1) begin
                    score <= score + PTS_GOOD;
                end
                hist0 <= user_note;
                hist1 <= hist0;
            end
        end
    end

endmodule

// ==== tb_chart_player.sv ====
module tb_chart_player import chart_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TB_CHART_LEN = 20;
    localparam int WATCHDOG_CYCLES = 5 * (4 * COUNT_TICKS + CHART_LEN * NOTE_TICKS + 100);
    localparam int RUN_LIMIT = 1000;

    // Play modes of the stimulus loop
    localparam int MODE_AUTO = 0;
    localparam int MODE_COPY = 1;
    localparam int MODE_SILENT = 2;
    localparam int MODE_WRONG = 3;

    logic      prog_clk;
    logic      rst;
    note_t     user_note;
    logic      auto_play;
    logic      free_play;
    note_t     chart_note;
    note_idx_t chart_len;
    logic      save_key;
    logic      exit_key;
    chart_id_t chart_id;
    logic      credit_return;
    digit_t    count_digit;
    logic      play_started;
    logic      playing;
    logic      finished;
    note_idx_t note_index;
    note_t     play_note;
    led_t      led;
    score_t    score;
    score_t    max_score;
    logic      exit_req;
    logic      rec_valid;
    note_idx_t rec_index;
    note_t     rec_note;
    chart_id_t rec_chart_id;
    logic      save_busy;

    note_t      rom [64];
    logic [15:0] lfsr_state;
    int         errors;
    int         tests_run;
    int         tests_failed;

    chart_player dut0 (.*);

    // Chart ROM answers the note index without delay
    assign chart_note = rom[note_index];

    initial prog_clk = 1'b0;
    always #5 prog_clk = ~prog_clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge prog_clk);
        $display("Watchdog expired: the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    // LED word as the note should light it
    function automatic led_t expected_led(input note_t n);
        led_t l;
        int   keys;
        l = '0;
        keys = 0;
        l[0] = n[8] | n[7];
        for (int i = 0; i < 7; i++) begin
            keys = keys + int'(n[i]);
        end
        // Key k counted from C sits on note bit 6-k and LED bit 7-k
        if (keys == 1) begin
            for (int k = 0; k < 7; k++) begin
                l[7-k] = n[6-k];
            end
        end
        return l;
    endfunction

    // Full marks: three scans of five points per keyed note
    function automatic int expected_max();
        int m;
        m = 0;
        for (int i = 0; i < TB_CHART_LEN; i++) begin
            if (rom[i][6:0] != 7'd0) begin
                m = m + 15;
            end
        end
        return m;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic fail_msg(input string what);
        $display("Error at t=%0t: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic fill_rom();
        int   oct;
        int   key;
        note_t n;
        for (int i = 0; i < 64; i++) begin
            n = '0;
            oct = rand_bits(2);
            // Octave 11 is kept for the wrong-key player
            if (oct == 3) begin
                oct = 0;
            end
            n[8:7] = 2'(oct);
            key = rand_bits(3) % 7;
            if (rand_bits(2) != 0) begin
                n[key] = 1'b1;
            end
            rom[i] = n;
        end
    endtask

    task automatic apply_reset(input logic auto_mode, input logic free_mode);
        rst = 1'b1;
        user_note = '0;
        save_key = 1'b0;
        exit_key = 1'b0;
        credit_return = 1'b0;
        chart_id = '0;
        auto_play = auto_mode;
        free_play = free_mode;
        chart_len = note_idx_t'(TB_CHART_LEN);
        repeat (8) @(posedge prog_clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic check_countdown();
        int n;
        n = 0;
        check_value("count_digit", int'(count_digit), 3);
        while (!play_started && n < 64) begin
            @(posedge prog_clk);
            #1;
            n++;
            if (!play_started) begin
                check_value("count_digit", int'(count_digit), 3 - n / COUNT_TICKS);
                check_value("playing", int'(playing), 0);
            end
        end
        check_value("play_started delay", n, 4 * COUNT_TICKS);
    endtask

    // Steps one run until finished, driving keys for the given mode
    task automatic play_run(input int mode, input int exit_at);
        int        cyc;
        int        wrong_key;
        note_idx_t prev_idx;
        note_t     n;
        cyc = 0;
        wrong_key = 0;
        prev_idx = note_index;
        while (!finished && cyc < RUN_LIMIT) begin
            @(posedge prog_clk);
            #1;
            cyc++;
            if (note_index != prev_idx) begin
                check_value("note_index", int'(note_index), int'(prev_idx) + 1);
                if (mode == MODE_AUTO) begin
                    check_value("play_note", int'(play_note), int'(rom[prev_idx]));
                    check_value("led", int'(led), int'(expected_led(rom[prev_idx])));
                end
                wrong_key = (wrong_key + 1) % 7;
                prev_idx = note_index;
            end
            if (exit_at > 0) begin
                check_value("exit_req", int'(exit_req), (cyc > exit_at) ? 1 : 0);
            end
            exit_key = (cyc == exit_at);
            n = '0;
            if (mode == MODE_COPY) begin
                n = rom[note_index];
            end else if (mode == MODE_WRONG) begin
                n[8:7] = 2'b11;
                n[wrong_key] = 1'b1;
            end
            user_note = n;
        end
        if (!finished) begin
            fail_msg("finished never rose");
        end
        exit_key = 1'b0;
    endtask

    task automatic save_run();
        int        cyc;
        int        beats;
        int        due;
        int        due_q[$];
        chart_id_t id;
        repeat (2) @(posedge prog_clk);
        #1;
        id = chart_id_t'(rand_bits(8));
        chart_id = id;
        save_key = 1'b1;
        @(posedge prog_clk);
        #1;
        save_key = 1'b0;
        cyc = 0;
        beats = 0;
        due = 0;
        while (beats < TB_CHART_LEN && cyc < 400) begin
            @(posedge prog_clk);
            #1;
            cyc++;
            if (rec_valid) begin
                check_value("rec_index", int'(rec_index), beats);
                check_value("rec_note", int'(rec_note), int'(rom[beats]));
                check_value("rec_chart_id", int'(rec_chart_id), int'(id));
                check_value("save_busy", int'(save_busy), 1);
                beats++;
                due = cyc + 1 + rand_bits(3);
                if (due_q.size() > 0 && due <= due_q[$]) begin
                    due = due_q[$] + 1;
                end
                due_q.push_back(due);
            end
            credit_return = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                credit_return = 1'b1;
            end
        end
        if (beats < TB_CHART_LEN) begin
            fail_msg("save stream stalled before the last beat");
        end
        @(posedge prog_clk);
        #1;
        credit_return = 1'b0;
        check_value("save_busy", int'(save_busy), 0);
        check_value("rec_valid", int'(rec_valid), 0);
    endtask

    initial begin
        int err0;
        lfsr_state = 16'd7782;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        user_note = '0;
        auto_play = 1'b0;
        free_play = 1'b0;
        chart_len = '0;
        save_key = 1'b0;
        exit_key = 1'b0;
        chart_id = '0;
        credit_return = 1'b0;
        fill_rom();

        err0 = errors;
        apply_reset(1'b1, 1'b0);
        check_countdown();
        end_test("countdown", err0);

        err0 = errors;
        play_run(MODE_AUTO, 0);
        check_value("note_index", int'(note_index), TB_CHART_LEN);
        check_value("max_score", int'(max_score), expected_max());
        check_value("score", int'(score), expected_max());
        end_test("auto play", err0);

        err0 = errors;
        apply_reset(1'b0, 1'b0);
        play_run(MODE_COPY, 0);
        check_value("max_score", int'(max_score), expected_max());
        check_value("score", int'(score), expected_max());
        end_test("user copy", err0);

        err0 = errors;
        save_run();
        end_test("save stream", err0);

        err0 = errors;
        apply_reset(1'b0, 1'b0);
        play_run(MODE_SILENT, 0);
        check_value("max_score", int'(max_score), expected_max());
        check_value("score", int'(score), 0);
        apply_reset(1'b0, 1'b0);
        play_run(MODE_WRONG, 0);
        check_value("max_score", int'(max_score), expected_max());
        check_value("score", int'(score), 0);
        end_test("silent and wrong keys", err0);

        err0 = errors;
        apply_reset(1'b0, 1'b1);
        play_run(MODE_COPY, 4 * COUNT_TICKS + 50);
        check_value("note_index", int'(note_index), CHART_LEN - 1);
        check_value("score", int'(score), 0);
        check_value("max_score", int'(max_score), 0);
        check_value("exit_req", int'(exit_req), 1);
        end_test("free play and exit", err0);

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
